// File: dram_front_pkg.sv
package dram_front_pkg;

	// request address and data
	localparam int addr_width = 30; // flat word address
	localparam int data_width = 32;

	// mapped address fields
	localparam int bg_width   = 2;
	localparam int bank_width = 2;
	localparam int row_width  = 16;
	localparam int col_width  = 10;

	localparam int bank_sel_width = bg_width + bank_width; // bank group and bank together
	localparam int bank_count     = 16;                    // 4 groups of 4 banks

	// configuration registers
	localparam int cfg_width      = 8;
	localparam int cfg_addr_width = 2;

	// register values after reset
	localparam int def_read_limit  = 32;
	localparam int def_write_limit = 32;
	localparam int def_bank_busy   = 6;

	typedef enum logic {
		kind_read,
		kind_write
	} req_kind_t;

	// 30 bits, bank group in the top bits
	typedef struct packed {
		logic [bg_width-1:0]   bank_group;
		logic [bank_width-1:0] bank;
		logic [row_width-1:0]  row;
		logic [col_width-1:0]  column;
	} mapped_addr_t;

endpackage

// File: req_mapper.sv
module req_mapper #(
	parameter int perm_shift = 5,
	parameter int slot_log   = 6
) (
	input  logic                                  clk,
	input  logic                                  rst_n,
	input  logic                                  in_valid_i,
	input  dram_front_pkg::req_kind_t             in_kind_i,
	input  logic [dram_front_pkg::addr_width-1:0] in_addr_i,
	input  logic [dram_front_pkg::data_width-1:0] in_data_i,
	input  logic                                  stop_read_i,
	input  logic                                  stop_write_i,
	input  logic [dram_front_pkg::bank_count-1:0] bank_busy_i,
	output logic                                  busy_o,
	output logic                                  issue_valid_o,
	output dram_front_pkg::req_kind_t             issue_kind_o,
	output dram_front_pkg::mapped_addr_t          issue_addr_o,
	output logic [dram_front_pkg::data_width-1:0] issue_data_o,
	output logic [slot_log-1:0]                   issue_index_o,
	output logic [dram_front_pkg::bank_count-1:0] bank_valid_o
);

	localparam int sel_width = dram_front_pkg::bank_sel_width;

	dram_front_pkg::mapped_addr_t in_map; // incoming address after permutation

	// one-entry wait register
	logic                                  park_valid;
	dram_front_pkg::req_kind_t             park_kind;
	dram_front_pkg::mapped_addr_t          park_addr;
	logic [dram_front_pkg::data_width-1:0] park_data;

	// request under evaluation this cycle
	logic                                  sel_valid;
	dram_front_pkg::req_kind_t             sel_kind;
	dram_front_pkg::mapped_addr_t          sel_addr;
	logic [dram_front_pkg::data_width-1:0] sel_data;
	logic [sel_width-1:0]                  sel_bank;
	logic                                  sel_stop;
	logic                                  go;
	logic [dram_front_pkg::bank_count-1:0] go_onehot;

	logic [slot_log-1:0] rd_slot; // next read index
	logic [slot_log-1:0] wr_slot; // next write index

	// bank bits are xored with upper row bits so row strides spread over banks
	always_comb begin
		in_map.row        = in_addr_i[29:14];
		in_map.column     = {in_addr_i[11:6], in_addr_i[3:0]};
		in_map.bank_group = in_addr_i[5:4] ^ in_addr_i[32-perm_shift:31-perm_shift];
		in_map.bank       = in_addr_i[13:12] ^ in_addr_i[30-perm_shift:29-perm_shift];
	end

	// parked request has priority, requester is held off meanwhile
	assign sel_valid = park_valid | in_valid_i;
	assign sel_kind  = park_valid ? park_kind : in_kind_i;
	assign sel_addr  = park_valid ? park_addr : in_map;
	assign sel_data  = park_valid ? park_data : in_data_i;
	assign sel_bank  = {sel_addr.bank_group, sel_addr.bank};

	assign sel_stop  = (sel_kind == dram_front_pkg::kind_read) ? stop_read_i : stop_write_i;
	assign go        = sel_valid & ~bank_busy_i[sel_bank] & ~sel_stop;
	assign go_onehot = dram_front_pkg::bank_count'(1) << sel_bank;

	assign busy_o = park_valid; // high for as long as a request waits

	// strobes, wait flag and slot counters
	always_ff @(posedge clk) begin
		if (rst_n) begin // rst_n high holds reset
			park_valid    <= 1'b0;
			issue_valid_o <= 1'b0;
			issue_kind_o  <= dram_front_pkg::kind_read;
			bank_valid_o  <= '0;
			rd_slot       <= '0;
			wr_slot       <= '0;
		end else begin
			issue_valid_o <= go;
			bank_valid_o  <= go ? go_onehot : '0;
			park_valid    <= sel_valid & ~go; // stalled, keep waiting
			if (go) begin
				issue_kind_o <= sel_kind;
				if (sel_kind == dram_front_pkg::kind_read) begin
					rd_slot <= rd_slot + 1'b1; // wraps at 2**slot_log
				end else begin
					wr_slot <= wr_slot + 1'b1;
				end
			end
		end
	end

	// issue payload, held between issues
	always_ff @(posedge clk) begin
		if (go) begin
			issue_addr_o  <= sel_addr;
			issue_data_o  <= sel_data; // parked data when the parked request leaves
			issue_index_o <= (sel_kind == dram_front_pkg::kind_read) ? rd_slot : wr_slot;
		end
	end

	// capture every new request, only kept if it stalls
	always_ff @(posedge clk) begin
		if (in_valid_i && !park_valid) begin
			park_kind <= in_kind_i;
			park_addr <= in_map;
			park_data <= in_data_i;
		end
	end

endmodule

// File: bank_tracker.sv
module bank_tracker (
	input  logic                                  clk,
	input  logic                                  rst_n,
	input  logic [dram_front_pkg::bank_count-1:0] bank_valid_i,
	input  logic [dram_front_pkg::cfg_width-1:0]  busy_cycles_i,
	output logic [dram_front_pkg::bank_count-1:0] bank_busy_o
);

	localparam int cnt_width = dram_front_pkg::cfg_width;

	// remaining busy cycles after the issue cycle
	logic [cnt_width-1:0] busy_cnt [dram_front_pkg::bank_count];

	genvar b;

	generate
		for (b = 0; b < dram_front_pkg::bank_count; b++) begin : g_bank
			always_ff @(posedge clk) begin
				if (rst_n) begin
					busy_cnt[b] <= '0;
				end else if (bank_valid_i[b]) begin
					busy_cnt[b] <= busy_cycles_i; // value at the issue counts
				end else if (busy_cnt[b] != '0) begin
					busy_cnt[b] <= busy_cnt[b] - cnt_width'(1);
				end
			end

			// issue bit covers the issue cycle itself, so a back-to-back
			// request to the same bank sees busy before the counter loads
			assign bank_busy_o[b] = bank_valid_i[b] | (busy_cnt[b] != '0);
		end
	endgenerate

endmodule

// File: flow_limiter.sv
module flow_limiter #(
	parameter int slot_log = 6
) (
	input  logic                                 clk,
	input  logic                                 rst_n,
	input  logic                                 issue_valid_i,
	input  dram_front_pkg::req_kind_t            issue_kind_i,
	input  logic                                 rd_done_i,
	input  logic                                 wr_done_i,
	input  logic [dram_front_pkg::cfg_width-1:0] read_limit_i,
	input  logic [dram_front_pkg::cfg_width-1:0] write_limit_i,
	output logic                                 stop_read_o,
	output logic                                 stop_write_o
);

	localparam int cnt_width = slot_log + 1;
	localparam int cmp_width = (cnt_width + 1 > dram_front_pkg::cfg_width) ?
		cnt_width + 1 : dram_front_pkg::cfg_width;

	logic [cnt_width-1:0] rd_cnt; // outstanding reads
	logic [cnt_width-1:0] wr_cnt; // outstanding writes
	logic                 rd_issue;
	logic                 wr_issue;
	logic [cmp_width-1:0] rd_pending;
	logic [cmp_width-1:0] wr_pending;

	// one up, one down, both together cancel
	function automatic logic [cnt_width-1:0] next_count(
		input logic [cnt_width-1:0] cnt,
		input logic                 inc,
		input logic                 dec
	);
		logic [cnt_width-1:0] nxt;
		nxt = cnt;
		if (inc && !dec) begin
			nxt = cnt + cnt_width'(1);
		end else if (dec && !inc && cnt != '0) begin
			nxt = cnt - cnt_width'(1);
		end
		return nxt;
	endfunction

	assign rd_issue = issue_valid_i && (issue_kind_i == dram_front_pkg::kind_read);
	assign wr_issue = issue_valid_i && (issue_kind_i == dram_front_pkg::kind_write);

	// count plus an issue in this cycle, not yet in the counter
	assign rd_pending = cmp_width'(rd_cnt) + cmp_width'(rd_issue);
	assign wr_pending = cmp_width'(wr_cnt) + cmp_width'(wr_issue);

	assign stop_read_o  = rd_pending >= cmp_width'(read_limit_i);
	assign stop_write_o = wr_pending >= cmp_width'(write_limit_i);

	always_ff @(posedge clk) begin
		if (rst_n) begin
			rd_cnt <= '0;
			wr_cnt <= '0;
		end else begin
			rd_cnt <= next_count(rd_cnt, rd_issue, rd_done_i);
			wr_cnt <= next_count(wr_cnt, wr_issue, wr_done_i);
		end
	end

endmodule

// File: front_cfg.sv
module front_cfg #(
	parameter int reset_read_limit  = 32,
	parameter int reset_write_limit = 32,
	parameter int reset_bank_busy   = 6
) (
	input  logic                                      clk,
	input  logic                                      rst_n,
	input  logic                                      cfg_we_i,
	input  logic [dram_front_pkg::cfg_addr_width-1:0] cfg_addr_i,
	input  logic [dram_front_pkg::cfg_width-1:0]      cfg_wdata_i,
	output logic [dram_front_pkg::cfg_width-1:0]      cfg_rdata_o,
	output logic [dram_front_pkg::cfg_width-1:0]      read_limit_o,
	output logic [dram_front_pkg::cfg_width-1:0]      write_limit_o,
	output logic [dram_front_pkg::cfg_width-1:0]      bank_busy_cycles_o
);

	localparam int w = dram_front_pkg::cfg_width;

	// register map
	localparam logic [dram_front_pkg::cfg_addr_width-1:0] reg_read_limit  = 2'd0;
	localparam logic [dram_front_pkg::cfg_addr_width-1:0] reg_write_limit = 2'd1;
	localparam logic [dram_front_pkg::cfg_addr_width-1:0] reg_bank_busy   = 2'd2;

	always_ff @(posedge clk) begin
		if (rst_n) begin
			read_limit_o       <= w'(reset_read_limit);
			write_limit_o      <= w'(reset_write_limit);
			bank_busy_cycles_o <= w'(reset_bank_busy);
		end else if (cfg_we_i) begin
			case (cfg_addr_i)
				reg_read_limit:  read_limit_o       <= cfg_wdata_i;
				reg_write_limit: write_limit_o      <= cfg_wdata_i;
				reg_bank_busy:   bank_busy_cycles_o <= cfg_wdata_i;
				default: ; // address 3 holds nothing
			endcase
		end
	end

	// read-back straight from the registers
	always_comb begin
		case (cfg_addr_i)
			reg_read_limit:  cfg_rdata_o = read_limit_o;
			reg_write_limit: cfg_rdata_o = write_limit_o;
			reg_bank_busy:   cfg_rdata_o = bank_busy_cycles_o;
			default:         cfg_rdata_o = '0;
		endcase
	end

endmodule

// File: dram_front_top.sv
module dram_front_top #(
	parameter int perm_shift = 5,
	parameter int slot_log   = 6
) (
	input  logic                                      clk,
	input  logic                                      rst_n,
	input  logic                                      in_valid_i,
	input  dram_front_pkg::req_kind_t                 in_kind_i,
	input  logic [dram_front_pkg::addr_width-1:0]     in_addr_i,
	input  logic [dram_front_pkg::data_width-1:0]     in_data_i,
	output logic                                      busy_o,
	output logic                                      issue_valid_o,
	output dram_front_pkg::req_kind_t                 issue_kind_o,
	output dram_front_pkg::mapped_addr_t              issue_addr_o,
	output logic [dram_front_pkg::data_width-1:0]     issue_data_o,
	output logic [slot_log-1:0]                       issue_index_o,
	output logic [dram_front_pkg::bank_count-1:0]     bank_valid_o,
	input  logic                                      rd_done_i,
	input  logic                                      wr_done_i,
	input  logic                                      cfg_we_i,
	input  logic [dram_front_pkg::cfg_addr_width-1:0] cfg_addr_i,
	input  logic [dram_front_pkg::cfg_width-1:0]      cfg_wdata_i,
	output logic [dram_front_pkg::cfg_width-1:0]      cfg_rdata_o
);

	logic [dram_front_pkg::bank_count-1:0] bank_busy;
	logic                                  stop_read;
	logic                                  stop_write;
	logic [dram_front_pkg::cfg_width-1:0]  read_limit;
	logic [dram_front_pkg::cfg_width-1:0]  write_limit;
	logic [dram_front_pkg::cfg_width-1:0]  bank_busy_cycles;

	req_mapper #(
		.perm_shift (perm_shift),
		.slot_log   (slot_log)
	) u_req_mapper (
		.clk           (clk),
		.rst_n         (rst_n),
		.in_valid_i    (in_valid_i),
		.in_kind_i     (in_kind_i),
		.in_addr_i     (in_addr_i),
		.in_data_i     (in_data_i),
		.stop_read_i   (stop_read),
		.stop_write_i  (stop_write),
		.bank_busy_i   (bank_busy),
		.busy_o        (busy_o),
		.issue_valid_o (issue_valid_o),
		.issue_kind_o  (issue_kind_o),
		.issue_addr_o  (issue_addr_o),
		.issue_data_o  (issue_data_o),
		.issue_index_o (issue_index_o),
		.bank_valid_o  (bank_valid_o)
	);

	bank_tracker u_bank_tracker (
		.clk           (clk),
		.rst_n         (rst_n),
		.bank_valid_i  (bank_valid_o),
		.busy_cycles_i (bank_busy_cycles),
		.bank_busy_o   (bank_busy)
	);

	flow_limiter #(
		.slot_log (slot_log)
	) u_flow_limiter (
		.clk           (clk),
		.rst_n         (rst_n),
		.issue_valid_i (issue_valid_o),
		.issue_kind_i  (issue_kind_o),
		.rd_done_i     (rd_done_i),
		.wr_done_i     (wr_done_i),
		.read_limit_i  (read_limit),
		.write_limit_i (write_limit),
		.stop_read_o   (stop_read),
		.stop_write_o  (stop_write)
	);

	front_cfg #(
		.reset_read_limit  (dram_front_pkg::def_read_limit),
		.reset_write_limit (dram_front_pkg::def_write_limit),
		.reset_bank_busy   (dram_front_pkg::def_bank_busy)
	) u_front_cfg (
		.clk                (clk),
		.rst_n              (rst_n),
		.cfg_we_i           (cfg_we_i),
		.cfg_addr_i         (cfg_addr_i),
		.cfg_wdata_i        (cfg_wdata_i),
		.cfg_rdata_o        (cfg_rdata_o),
		.read_limit_o       (read_limit),
		.write_limit_o      (write_limit),
		.bank_busy_cycles_o (bank_busy_cycles)
	);

endmodule

// File: tb_clk_gen.sv
module tb_clk_gen #(
	parameter int reset_cycles = 8
) (
	output logic clk,
	output logic rst_n
);
	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk; // 10 ns period
	end

	initial begin
		rst_n = 1'b1; // reset is active high
		repeat (reset_cycles) @(posedge clk);
		#1 rst_n = 1'b0;
	end

endmodule

// File: tb_dram_front.sv
module tb_dram_front;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int perm_shift = 5;
	localparam int slot_log   = 6;
	localparam int max_cycles = 20000; // about four times the summed test lengths

	typedef struct packed {
		dram_front_pkg::req_kind_t    kind;
		dram_front_pkg::mapped_addr_t addr;
		logic [31:0]                  data;
		logic [slot_log-1:0]          index;
	} exp_t;

	logic                         clk;
	logic                         rst_n;
	logic                         in_valid_i;
	dram_front_pkg::req_kind_t    in_kind_i;
	logic [29:0]                  in_addr_i;
	logic [31:0]                  in_data_i;
	logic                         busy_o;
	logic                         issue_valid_o;
	dram_front_pkg::req_kind_t    issue_kind_o;
	dram_front_pkg::mapped_addr_t issue_addr_o;
	logic [31:0]                  issue_data_o;
	logic [slot_log-1:0]          issue_index_o;
	logic [15:0]                  bank_valid_o;
	logic                         rd_done_i;
	logic                         wr_done_i;
	logic                         cfg_we_i;
	logic [1:0]                   cfg_addr_i;
	logic [7:0]                   cfg_wdata_i;
	logic [7:0]                   cfg_rdata_o;

	exp_t                exp_q [$]; // accepted requests in order
	logic [slot_log-1:0] rd_idx;
	logic [slot_log-1:0] wr_idx;
	logic [7:0]          cfg_model [4];
	int                  rd_out, wr_out; // outstanding as the DUT counts them
	int                  bank_last [16];
	int                  bank_hold [16]; // busy setting at the last issue
	bit [15:0]           bank_seen;
	int                  last_gap;
	int                  issue_count;
	int                  seed;
	int                  cycle;
	int                  err_count, err_mark, n_checks, n_tests;
	bit                  auto_done;

	tb_clk_gen u_clk_gen (
		.clk   (clk),
		.rst_n (rst_n)
	);

	dram_front_top #(
		.perm_shift (perm_shift),
		.slot_log   (slot_log)
	) dut0 (.*);

	task automatic compare(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		n_checks++;
		if (actual !== expected) begin
			err_count++;
			$display("ERROR at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
		end
	endtask

	function automatic dram_front_pkg::mapped_addr_t map_addr(input logic [29:0] a);
		dram_front_pkg::mapped_addr_t m;
		m.row        = a[29:14];
		m.column     = {a[11:6], a[3:0]};
		m.bank_group = a[5:4] ^ 2'(a >> (31 - perm_shift)); // bits 32-t down to 31-t
		m.bank       = a[13:12] ^ 2'(a >> (29 - perm_shift));
		return m;
	endfunction

	// upper row bits used by the xor are cleared, raw bank bits pick the bank
	function automatic logic [29:0] addr_for_bank(input logic [3:0] bank, input logic [29:0] r);
		return (r & ~30'h0f00_3030) | {16'd0, bank[1:0], 6'd0, bank[3:2], 4'd0};
	endfunction

	task automatic next_cycle();
		logic [31:0] rnd;
		@(posedge clk);
		#1;
		in_valid_i = 1'b0;
		rd_done_i  = 1'b0;
		wr_done_i  = 1'b0;
		if (auto_done) begin
			rnd = $random(seed);
			if (rnd[0] && rd_out > 0) begin
				rd_done_i = 1'b1;
				rd_out--;
			end
			if (rnd[1] && wr_out > 0) begin
				wr_done_i = 1'b1;
				wr_out--;
			end
		end
	endtask

	task automatic send_req(input dram_front_pkg::req_kind_t kind, input logic [29:0] addr,
			input logic [31:0] data);
		exp_t e;
		while (busy_o) begin
			next_cycle();
		end
		in_valid_i = 1'b1;
		in_kind_i  = kind;
		in_addr_i  = addr;
		in_data_i  = data;
		e.kind     = kind;
		e.addr     = map_addr(addr);
		e.data     = data;
		if (kind == dram_front_pkg::kind_read) begin
			e.index = rd_idx;
			rd_idx  = rd_idx + slot_log'(1);
		end else begin
			e.index = wr_idx;
			wr_idx  = wr_idx + slot_log'(1);
		end
		exp_q.push_back(e);
		next_cycle();
	endtask

	// drain issues and completions, then let every bank go idle
	task automatic settle();
		auto_done = 1'b0;
		while (exp_q.size() != 0 || rd_out != 0 || wr_out != 0) begin
			next_cycle();
			if (rd_out > 0) begin
				rd_done_i = 1'b1;
				rd_out--;
			end
			if (wr_out > 0) begin
				wr_done_i = 1'b1;
				wr_out--;
			end
		end
		repeat (int'(cfg_model[2]) + 2) next_cycle();
	endtask

	task automatic cfg_write(input logic [1:0] addr, input logic [7:0] value);
		cfg_we_i    = 1'b1;
		cfg_addr_i  = addr;
		cfg_wdata_i = value;
		next_cycle();
		cfg_we_i = 1'b0;
		if (addr != 2'd3) begin
			cfg_model[addr] = value;
		end
	endtask

	task automatic cfg_read(input logic [1:0] addr);
		cfg_addr_i = addr;
		#2;
		compare("cfg_rdata_o", 64'(cfg_model[addr]), 64'(cfg_rdata_o));
		next_cycle();
	endtask

	task automatic check_idle();
		compare("busy_o", 64'd0, 64'(busy_o));
		compare("issue_valid_o", 64'd0, 64'(issue_valid_o));
		compare("bank_valid_o", 64'd0, 64'(bank_valid_o));
	endtask

	// two writes to one bank, the second parks and must keep its own data
	task automatic conflict_pair(input logic [3:0] bank);
		logic [31:0] r;
		logic [31:0] d;
		logic [29:0] a;
		r = $random(seed);
		d = $random(seed);
		a = addr_for_bank(bank, r[29:0]);
		send_req(dram_front_pkg::kind_write, a, d);
		send_req(dram_front_pkg::kind_write, a ^ 30'h0010_0040, ~d); // same bank, other row
		compare("busy_o", 64'd1, 64'(busy_o));
		in_data_i = d ^ 32'h5a5a_5a5a; // live data differs from the parked data
		settle();
		compare("same-bank issue gap", 64'(cfg_model[2]) + 64'd2, 64'(last_gap));
	endtask

	task automatic limit_run(input dram_front_pkg::req_kind_t kind, input logic [1:0] reg_addr,
			input int first_bank);
		logic [31:0] r;
		int base;
		int i;
		cfg_write(reg_addr, 8'd4);
		base = issue_count;
		for (i = 0; i < 5; i++) begin
			r = $random(seed);
			send_req(kind, addr_for_bank(4'(first_bank + i), r[29:0]), r);
		end
		repeat (20) next_cycle();
		compare("issue_valid_o count", 64'd4, 64'(issue_count - base));
		compare("busy_o", 64'd1, 64'(busy_o));
		if (kind == dram_front_pkg::kind_read) begin
			rd_done_i = 1'b1;
			rd_out--;
		end else begin
			wr_done_i = 1'b1;
			wr_out--;
		end
		repeat (20) next_cycle();
		compare("issue_valid_o count", 64'd5, 64'(issue_count - base));
		compare("busy_o", 64'd0, 64'(busy_o));
		settle();
		cfg_write(reg_addr, 8'd32);
	endtask

	task automatic end_test(input string name);
		$display("test %s finished with %0d errors", name, err_count - err_mark);
		err_mark = err_count;
		n_tests++;
	endtask

	// issue monitor, registered outputs are settled at the falling edge
	always @(negedge clk) begin
		exp_t e;
		logic [3:0] bank;
		if (!rst_n && issue_valid_o) begin
			issue_count++;
			if (exp_q.size() == 0) begin
				err_count++;
				$display("issue at %0t ns with no accepted request left in the model", $time);
			end else begin
				e    = exp_q.pop_front();
				bank = {e.addr.bank_group, e.addr.bank};
				compare("issue_kind_o", 64'(e.kind), 64'(issue_kind_o));
				compare("issue_addr_o", 64'(e.addr), 64'(issue_addr_o));
				compare("issue_index_o", 64'(e.index), 64'(issue_index_o));
				compare("bank_valid_o", 64'(16'd1 << bank), 64'(bank_valid_o));
				if (e.kind == dram_front_pkg::kind_write) begin
					compare("issue_data_o", 64'(e.data), 64'(issue_data_o));
				end
				if (bank_seen[bank]) begin
					last_gap = cycle - bank_last[bank];
					if (last_gap < bank_hold[bank] + 2) begin // free only after hold + 1
						err_count++;
						$display("bank %0d issued at %0t ns while still busy", bank, $time);
					end
				end
				bank_seen[bank] = 1'b1;
				bank_last[bank] = cycle;
				bank_hold[bank] = int'(cfg_model[2]);
				if (e.kind == dram_front_pkg::kind_read) begin
					rd_out++;
				end else begin
					wr_out++;
				end
			end
		end
	end

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= max_cycles) begin
			$display("timeout: the run did not finish within %0d cycles", max_cycles);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	initial begin
		logic [31:0] rnd;
		logic [31:0] data;
		int i;
		int j;
		seed        = 32'h91c5_c988;
		in_valid_i  = 1'b0;
		in_kind_i   = dram_front_pkg::kind_read;
		in_addr_i   = '0;
		in_data_i   = '0;
		rd_done_i   = 1'b0;
		wr_done_i   = 1'b0;
		cfg_we_i    = 1'b0;
		cfg_addr_i  = '0;
		cfg_wdata_i = '0;
		rd_idx      = '0;
		wr_idx      = '0;
		auto_done   = 1'b0;
		cfg_model[0] = 8'd32;
		cfg_model[1] = 8'd32;
		cfg_model[2] = 8'd6;
		cfg_model[3] = 8'd0; // unused address reads zero

		repeat (2) @(posedge clk);
		@(negedge clk);
		check_idle();
		wait (!rst_n);
		@(negedge clk);
		check_idle();
		next_cycle();
		cfg_read(2'd0);
		cfg_read(2'd1);
		cfg_read(2'd2);
		end_test("reset");

		auto_done = 1'b1;
		for (i = 0; i < 500; i++) begin
			rnd  = $random(seed);
			data = $random(seed);
			send_req(dram_front_pkg::req_kind_t'(rnd[31]), rnd[29:0], data);
			if (rnd[30]) begin
				next_cycle(); // idle gap
			end
		end
		settle();
		end_test("mapping");

		conflict_pair(4'd5);
		end_test("bank_conflict");

		limit_run(dram_front_pkg::kind_read, 2'd0, 0);
		limit_run(dram_front_pkg::kind_write, 2'd1, 8);
		end_test("flow_limit");

		for (i = 0; i < 16; i++) begin
			rnd = $random(seed);
			cfg_write(rnd[1:0], rnd[15:8]);
			for (j = 0; j < 4; j++) begin
				cfg_read(2'(j));
			end
		end
		cfg_write(2'd0, 8'd32);
		cfg_write(2'd1, 8'd32);
		cfg_write(2'd2, 8'd12);
		conflict_pair(4'd9);
		cfg_write(2'd2, 8'd0); // busy only in the issue cycle
		conflict_pair(4'd9);
		cfg_write(2'd2, 8'd6);
		end_test("config");

		$display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, err_count);
		if (err_count == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

// File: dram_front.f
dram_front_pkg.sv
req_mapper.sv
bank_tracker.sv
flow_limiter.sv
front_cfg.sv
dram_front_top.sv
tb_clk_gen.sv
tb_dram_front.sv

// File: run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator, fail if the log reports errors
set -e
cd "$(dirname "$0")"
verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
	-f dram_front.f --top-module tb_dram_front -o tb_dram_front
./obj_dir/tb_dram_front > sim.log
cat sim.log
if grep -q "ERRORS FOUND" sim.log; then
	exit 1
fi
